//--- vlog.f
+incdir+include
hw/fpuPkg.sv
hw/fpuCtrlIf.sv
hw/unpack.sv
hw/fcmp.sv
hw/fsgnClass.sv
hw/fexec.sv
hw/fctrl.sv
hw/fregfile.sv
hw/fhazard.sv
hw/fpuLite.sv
test/fpuLiteTb.sv

//--- Bender.yml
package:
  name: fpuLite

sources:
  - files:
      - hw/fpuPkg.sv
      - hw/fpuCtrlIf.sv
      - hw/unpack.sv
      - hw/fcmp.sv
      - hw/fsgnClass.sv
      - hw/fexec.sv
      - hw/fctrl.sv
      - hw/fregfile.sv
      - hw/fhazard.sv
      - hw/fpuLite.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/fpuLiteTb.sv

//--- include/fpuTbModel.svh
// Testbench reference model: expected record, model register file, FP rules, encoder, xorshift
`ifndef FPU_TB_MODEL_SVH
`define FPU_TB_MODEL_SVH

// What one instruction should show on the way down the pipe
typedef struct packed {
  logic        ill;    // IllegalFPUInstrD while in D
  logic        iw;     // Integer write in M
  logic [31:0] ires;
  logic [4:0]  flags;
  logic        fw;     // FP write in W
  logic [4:0]  rd;
  logic [31:0] fres;
} expT;

logic [31:0] modelRegs [32] = '{default: '0};  // Architectural f0..f31
logic [31:0] rngState = 32'he98b;

function automatic logic [31:0] xorshift32();
  rngState ^= rngState << 13;
  rngState ^= rngState >> 17;
  rngState ^= rngState << 5;
  return rngState;
endfunction

function automatic logic [31:0] encFp(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] rm,
                                      input logic [4:0] rd);
  return {f7, rs2, rs1, rm, rd, OPFP};
endfunction

function automatic logic isNan(input logic [31:0] v);
  return (v[30:23] == 8'hff) && (v[22:0] != 23'd0);
endfunction

function automatic logic isSnan(input logic [31:0] v);
  return isNan(v) && !v[22];  // Quiet bit clear
endfunction

function automatic logic isZero(input logic [31:0] v);
  return v[30:0] == 31'd0;
endfunction

// Unsigned key in real-number order, -0 just below +0
function automatic logic [31:0] orderKey(input logic [31:0] v);
  return v[31] ? ~v : (v | 32'h80000000);
endfunction

// Standard RISC-V fclass mask
function automatic logic [31:0] classMask(input logic [31:0] v);
  logic [9:0] m;
  m = '0;
  if (isNan(v))                m[v[22] ? 9 : 8] = 1'b1;
  else if (v[30:23] == 8'hff)  m[v[31] ? 0 : 7] = 1'b1;  // Infinity
  else if (isZero(v))          m[v[31] ? 3 : 4] = 1'b1;
  else if (v[30:23] == 8'h00)  m[v[31] ? 2 : 5] = 1'b1;  // Subnormal
  else                         m[v[31] ? 1 : 6] = 1'b1;
  return {22'd0, m};
endfunction

// Mostly special values, the rest plain random bits
function automatic logic [31:0] randOperand();
  logic [31:0] r, s;
  r = xorshift32();
  s = xorshift32();
  case (r[3:0])
    4'd0:    return {s[31], 31'd0};
    4'd1:    return {s[31], 8'hff, 23'd0};
    4'd2:    return {s[31], 8'hff, 1'b1, s[21:0]};        // Quiet NaN
    4'd3:    return {s[31], 8'hff, 2'b01, s[20:0]};       // Signaling NaN, payload nonzero
    4'd4:    return {s[31], 8'h00, s[22:1], 1'b1};        // Subnormal
    default: return s;
  endcase
endfunction

// Expected result of one instruction, read from the model registers in program order
function automatic expT predict(input logic [31:0] instr, input logic [31:0] srcA);
  expT         e;
  logic [6:0]  f7;
  logic [2:0]  rm;
  logic [4:0]  rs2;
  logic [31:0] x, y;
  logic        eq, lt, anyNan;
  e      = '0;
  f7     = instr[31:25];
  rm     = instr[14:12];
  rs2    = instr[24:20];
  x      = modelRegs[instr[19:15]];
  y      = modelRegs[rs2];
  anyNan = isNan(x) || isNan(y);
  eq     = !anyNan && ((isZero(x) && isZero(y)) || x == y);
  lt     = !anyNan && !eq && (orderKey(x) < orderKey(y));
  if (instr[6:0] == OPFP) begin
    case (f7)
      FSGNJ: begin
        e.fw   = rm <= 3'd2;
        e.fres = {(rm == 3'd0) ? y[31] : (rm == 3'd1) ? ~y[31] : x[31] ^ y[31], x[30:0]};
      end
      FMINMAX: begin
        e.fw = rm <= 3'd1;
        if (isNan(x) && isNan(y)) e.fres = CANONNAN;
        else if (isNan(x))        e.fres = y;
        else if (isNan(y))        e.fres = x;
        else e.fres = ((orderKey(x) < orderKey(y)) == (rm == 3'd0)) ? x : y;
        e.flags[NV_BIT] = e.fw && (isSnan(x) || isSnan(y));
      end
      FCMP: begin
        e.iw   = rm <= 3'd2;
        e.ires = {31'd0, (rm == 3'd2) ? eq : (rm == 3'd1) ? lt : (lt || eq)};
        e.flags[NV_BIT] = e.iw && ((rm == 3'd2) ? (isSnan(x) || isSnan(y)) : anyNan);
      end
      FCLASSMV: begin
        e.iw   = (rs2 == 5'd0) && (rm <= 3'd1);
        e.ires = (rm == 3'd1) ? classMask(x) : x;  // fclass or fmv.x.w
      end
      FMVWX: begin
        e.fw   = (rs2 == 5'd0) && (rm == 3'd0);
        e.fres = srcA;
      end
      default: ;
    endcase
    e.ill = !(e.fw || e.iw);
  end
  e.rd = e.fw ? instr[11:7] : 5'd0;
  return e;
endfunction

`endif

//--- test/fpuLiteTb.sv
// Testbench top with clock, reset, stimulus, expected-value pipe, checking assertions and report
`timescale 1ns/100ps

module fpuLiteTb;
  import fpuPkg::*;
  `include "fpuTbModel.svh"

  localparam logic [31:0] NOP = 32'h00000013;  // addi x0, x0, 0

  logic        clk = 1'b0;
  logic        rstN, Stall, FlushE;
  logic [31:0] InstrD, SrcAE;
  logic        IllegalFPUInstrD, FWriteIntM, FRegWriteW;
  logic [31:0] FIntResM, FResultW;
  logic [4:0]  SetFflagsM, RdW;

  expT         dExp, expE, expM, expW;  // Expected record per stage
  logic [31:0] eSrc;                    // SrcAE owed to the instruction in E
  int          errors = 0;
  bit          timedOut = 1'b0;
  string       testNames [6] = '{"moves", "sign injection", "classify",
                                 "compare and min/max", "forwarding and stalls",
                                 "illegal decode"};

  always #5 clk = ~clk;

  fpuLite UUT (.*);

  // Expected values ride along with the DUT's stages
  always @(posedge clk) begin
    if (!rstN) begin
      expE <= '0;
      expM <= '0;
      expW <= '0;
    end else if (!Stall) begin
      expE <= FlushE ? '0 : dExp;  // Flushed slot is a bubble
      expM <= expE;
      expW <= expM;
    end
  end

  task automatic reportValue(input string name, input logic [31:0] expv, input logic [31:0] got);
    $display("FAIL %s expected %h got %h", name, expv, got);
    errors++;
  endtask

  ////////////////////
  // Checks
  ////////////////////
  assert property (@(posedge clk) disable iff (!rstN) IllegalFPUInstrD == dExp.ill)
    else reportValue("IllegalFPUInstrD", $sampled(dExp.ill), $sampled(IllegalFPUInstrD));
  assert property (@(posedge clk) disable iff (!rstN) FWriteIntM == expM.iw)
    else reportValue("FWriteIntM", $sampled(expM.iw), $sampled(FWriteIntM));
  assert property (@(posedge clk) disable iff (!rstN) expM.iw |-> FIntResM == expM.ires)
    else reportValue("FIntResM", $sampled(expM.ires), $sampled(FIntResM));
  assert property (@(posedge clk) disable iff (!rstN) SetFflagsM == expM.flags)
    else reportValue("SetFflagsM", $sampled(expM.flags), $sampled(SetFflagsM));
  assert property (@(posedge clk) disable iff (!rstN) FRegWriteW == expW.fw)
    else reportValue("FRegWriteW", $sampled(expW.fw), $sampled(FRegWriteW));
  assert property (@(posedge clk) disable iff (!rstN) expW.fw |-> RdW == expW.rd)
    else reportValue("RdW", $sampled(expW.rd), $sampled(RdW));
  assert property (@(posedge clk) disable iff (!rstN) expW.fw |-> FResultW == expW.fres)
    else reportValue("FResultW", $sampled(expW.fres), $sampled(FResultW));

  ////////////////////
  // Stimulus
  ////////////////////
  task automatic driveCycle(input logic [31:0] instr, input logic [31:0] srcA, input bit stall,
                            input bit flush, input expT e);
    @(posedge clk);
    #1;
    InstrD = instr;
    Stall  = stall;
    FlushE = flush;
    SrcAE  = eSrc;             // Operand of the instruction now in E
    dExp   = e;
    if (!stall) eSrc = srcA;   // Enters E at the coming edge
  endtask

  task automatic issue(input logic [31:0] instr, input logic [31:0] srcA = 32'd0,
                       input bit flush = 1'b0, input bit stallFirst = 1'b0);
    expT e;
    e = predict(instr, srcA);
    if (stallFirst) driveCycle(instr, srcA, 1'b1, 1'b0, e);
    driveCycle(instr, srcA, 1'b0, flush, e);
    if (e.fw && !flush) modelRegs[e.rd] = e.fres;
  endtask

  task automatic loadReg(input logic [4:0] rd, input logic [31:0] v);
    issue(encFp(FMVWX, 5'd0, 5'd0, 3'd0, rd), v);  // fmv.w.x
  endtask

  task automatic drainPipe();
    int n;
    n = 0;
    issue(NOP);  // Last instruction leaves D
    while ((expE.fw || expE.iw || expM.fw || expM.iw || expW.fw) && n < 10) begin
      issue(NOP);
      n++;
    end
    if (expE.fw || expE.iw || expM.fw || expM.iw || expW.fw) begin
      $display("Pipeline did not drain within 10 cycles");
      timedOut = 1'b1;
    end
  endtask

  task automatic moveRoundTrip();
    logic [31:0] v;
    repeat (8) begin
      v = xorshift32();
      loadReg(v[4:0], v);
      issue(encFp(FCLASSMV, 5'd0, v[4:0], 3'd0, 5'd10));  // fmv.x.w with X forwarded from M
    end
  endtask

  task automatic signInjection();
    logic [31:0] r;
    repeat (16) begin
      r = xorshift32();
      loadReg(5'd1, randOperand());
      loadReg(5'd2, randOperand());
      issue(encFp(FSGNJ, 5'd2, 5'd1, 3'(r % 3), 5'd3));
    end
  endtask

  task automatic classifyValues();
    logic [31:0] vals [10] = '{32'hff800000, 32'hbf800000, 32'h80000001, 32'h80000000,
                               32'h00000000, 32'h007fffff, 32'h3f800000, 32'h7f800000,
                               32'h7f800001, 32'h7fc00000};
    foreach (vals[i]) begin
      loadReg(5'd4, vals[i]);
      issue(encFp(FCLASSMV, 5'd0, 5'd4, 3'd1, 5'd6));
    end
    repeat (12) begin
      loadReg(5'd4, randOperand());
      issue(encFp(FCLASSMV, 5'd0, 5'd4, 3'd1, 5'd6));
    end
  endtask

  // All five compare and min/max ops on one pair
  task automatic cmpCase(input logic [31:0] x, input logic [31:0] y);
    loadReg(5'd7, x);
    loadReg(5'd8, y);
    for (int i = 0; i < 5; i++)
      issue(encFp(i < 2 ? FMINMAX : FCMP, 5'd8, 5'd7, 3'(i < 2 ? i : 4 - i), 5'd9));
  endtask

  task automatic compareMinMax();
    logic [31:0] x, r;
    cmpCase(32'h7fc00000, 32'h7f800001);  // Both NaN
    cmpCase(32'h7f800001, 32'h3f800000);  // sNaN against a number
    cmpCase(32'h80000000, 32'h00000000);  // Signed zeros
    repeat (20) begin
      x = randOperand();
      r = xorshift32();
      case (r[1:0])
        2'd0:    cmpCase(x, x);
        2'd1:    cmpCase(x, x ^ 32'd1);     // Neighbour
        default: cmpCase(x, randOperand());
      endcase
    end
  endtask

  task automatic hazardChains();
    logic [31:0] r, instr;
    logic [4:0]  rd, rs1, rs2;
    for (int i = 1; i <= 4; i++) loadReg(5'(i), randOperand());
    repeat (40) begin
      r   = xorshift32();
      rd  = 5'(r[1:0]) + 5'd1;  // f1..f4 keeps chains dependent
      rs1 = 5'(r[3:2]) + 5'd1;
      rs2 = 5'(r[5:4]) + 5'd1;
      case (r[8:6])
        3'd0:    instr = encFp(FMVWX, 5'd0, 5'd0, 3'd0, rd);
        3'd1:    instr = encFp(FMINMAX, rs2, rs1, {2'b0, r[9]}, rd);
        3'd2:    instr = encFp(FCMP, rs2, rs1, {1'b0, r[10:9]}, 5'd10);
        3'd3:    instr = encFp(FCLASSMV, 5'd0, rs1, {2'b0, r[9]}, 5'd11);
        default: instr = encFp(FSGNJ, rs2, rs1, {1'b0, r[10:9]}, rd);
      endcase
      issue(instr, randOperand(), r[13:11] == 3'd0, r[16:14] == 3'd0);
    end
  endtask

  task automatic illegalDecode();
    loadReg(5'd3, 32'hdeadbeef);
    issue(encFp(FSGNJ, 5'd2, 5'd1, 3'd3, 5'd3));           // rm out of range
    issue(encFp(FMINMAX, 5'd2, 5'd1, 3'd2, 5'd3));
    issue(encFp(FCMP, 5'd2, 5'd1, 3'd3, 5'd3));
    issue(encFp(FCLASSMV, 5'd1, 5'd1, 3'd0, 5'd3));        // rs2 nonzero
    issue(encFp(FCLASSMV, 5'd0, 5'd1, 3'd2, 5'd3));
    issue(encFp(FMVWX, 5'd0, 5'd0, 3'd1, 5'd3), 32'h12345678);
    issue(encFp(FSGNJ | 7'd1, 5'd2, 5'd1, 3'd0, 5'd3));    // fmt 01
    issue(encFp(7'b0000000, 5'd2, 5'd1, 3'd0, 5'd3));      // fadd is not kept
    issue(32'h00208033);                                   // add has an integer opcode
    issue(32'h0000a187);                                   // flw has the load-FP opcode
    issue(encFp(FCLASSMV, 5'd0, 5'd3, 3'd0, 5'd10));       // f3 must be untouched
  endtask

  initial begin
    int errBefore;
    int okCount;
    rstN   = 1'b0;
    Stall  = 1'b0;
    FlushE = 1'b0;
    InstrD = NOP;
    SrcAE  = 32'd0;
    dExp   = '0;
    eSrc   = 32'd0;
    okCount = 0;
    repeat (16) @(posedge clk);
    #1;
    rstN = 1'b1;
    for (int t = 0; t < 6 && !timedOut; t++) begin
      errBefore = errors;
      case (t)
        0: moveRoundTrip();
        1: signInjection();
        2: classifyValues();
        3: compareMinMax();
        4: hazardChains();
        default: illegalDecode();
      endcase
      drainPipe();
      if (errors == errBefore && !timedOut) okCount++;
      $display("test %0d %s: %0d errors", t + 1, testNames[t], errors - errBefore);
    end
    $display("%0d of 6 tests clean, %0d check errors", okCount, errors);
    if (errors == 0 && !timedOut) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- hw/fpuLite.sv
// Top level: decoder, FP register file, hazard unit and execute datapath
`timescale 1ns/100ps

module fpuLite (
  input  logic                        clk,
  input  logic                        rstN,
  input  logic                        Stall,
  input  logic                        FlushE,
  input  logic [31:0]                 InstrD,
  input  logic [fpuPkg::FLEN-1:0]     SrcAE,
  output logic                        IllegalFPUInstrD,
  output logic [fpuPkg::FLEN-1:0]     FIntResM,
  output logic                        FWriteIntM,
  output logic [4:0]                  SetFflagsM,
  output logic                        FRegWriteW,
  output logic [fpuPkg::REGBITS-1:0]  RdW,
  output logic [fpuPkg::FLEN-1:0]     FResultW
);
  import fpuPkg::*;

  logic               fRegWriteM;          // M-stage FP write, for forwarding
  logic [REGBITS-1:0] rdM;
  logic [FLEN-1:0]    rd1E, rd2E;          // Register file read in E
  fwdSelT             forwardXE, forwardYE;

  fpuCtrlIf ctrl (.clk, .rstN);

  fctrl fctrlU (.clk, .rstN, .Stall, .FlushE, .InstrD, .ctrl(ctrl.dec), .IllegalFPUInstrD,
    .FWriteIntM, .FRegWriteM(fRegWriteM), .RdM(rdM), .FRegWriteW, .RdW);

  // Sources come from the E-stage addresses, W writes through
  fregfile fregfileU (.clk, .rstN, .Adr1(ctrl.Adr1E), .Adr2(ctrl.Adr2E), .Rd1(rd1E),
    .Rd2(rd2E), .We(FRegWriteW), .WAdr(RdW), .WData(FResultW));

  fhazard fhazardU (.ctrl(ctrl.exec), .FRegWriteM(fRegWriteM), .RdM(rdM), .FRegWriteW, .RdW,
    .ForwardXE(forwardXE), .ForwardYE(forwardYE));

  fexec fexecU (.clk, .rstN, .Stall, .ctrl(ctrl.exec), .Rd1(rd1E), .Rd2(rd2E),
    .ForwardXE(forwardXE), .ForwardYE(forwardYE), .SrcAE, .FIntResM, .SetFflagsM,
    .FResultM(), .FResultW);  // M result only feeds forwarding inside fexec

endmodule

//--- hw/fhazard.sv
// Forwarding selects for the X and Y operands in E
`timescale 1ns/100ps

module fhazard (
  fpuCtrlIf.exec                     ctrl,
  input  logic                       FRegWriteM,
  input  logic [fpuPkg::REGBITS-1:0] RdM,
  input  logic                       FRegWriteW,
  input  logic [fpuPkg::REGBITS-1:0] RdW,
  output fpuPkg::fwdSelT             ForwardXE,
  output fpuPkg::fwdSelT             ForwardYE
);
  import fpuPkg::*;

  // Youngest producer wins, M before W
  always_comb begin
    ForwardXE = fwdReg;
    ForwardYE = fwdReg;
    if (FRegWriteM && RdM == ctrl.Adr1E)      ForwardXE = fwdM;
    else if (FRegWriteW && RdW == ctrl.Adr1E) ForwardXE = fwdW;
    if (FRegWriteM && RdM == ctrl.Adr2E)      ForwardYE = fwdM;
    else if (FRegWriteW && RdW == ctrl.Adr2E) ForwardYE = fwdW;
  end

  // A forwarded select needs a live FP write in that stage
  assert property (@(posedge ctrl.clk) disable iff (!ctrl.rstN)
    ((ForwardXE == fwdM || ForwardYE == fwdM) |-> FRegWriteM) and
    ((ForwardXE == fwdW || ForwardYE == fwdW) |-> FRegWriteW))
    else $error("Forward select without a matching FP write");

endmodule

//--- hw/fregfile.sv
// FP register file, two read ports and one write-through write port
`timescale 1ns/100ps

module fregfile (
  input  logic                        clk,
  input  logic                        rstN,
  input  logic [fpuPkg::REGBITS-1:0]  Adr1,
  input  logic [fpuPkg::REGBITS-1:0]  Adr2,
  output logic [fpuPkg::FLEN-1:0]     Rd1,
  output logic [fpuPkg::FLEN-1:0]     Rd2,
  input  logic                        We,
  input  logic [fpuPkg::REGBITS-1:0]  WAdr,
  input  logic [fpuPkg::FLEN-1:0]     WData
);
  import fpuPkg::*;

  logic [FLEN-1:0] regs [2**REGBITS];  // f0..f31, f0 is an ordinary register

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < 2**REGBITS; i++) regs[i] <= '0;
    end else if (We) begin
      regs[WAdr] <= WData;
    end
  end

  // Write-through so a W-stage write is visible the same cycle
  assign Rd1 = (We && WAdr == Adr1) ? WData : regs[Adr1];
  assign Rd2 = (We && WAdr == Adr2) ? WData : regs[Adr2];

endmodule

//--- hw/fctrl.sv
// Instruction decoder, illegal-instruction check and D to W control pipeline
`timescale 1ns/100ps

module fctrl (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         Stall,             // Freezes every stage
  input  logic                         FlushE,            // Bubble into E
  input  logic [31:0]                  InstrD,
  fpuCtrlIf.dec                        ctrl,
  output logic                         IllegalFPUInstrD,  // Same-cycle decode fault
  output logic                         FWriteIntM,
  output logic                         FRegWriteM,
  output logic [fpuPkg::REGBITS-1:0]   RdM,
  output logic                         FRegWriteW,
  output logic [fpuPkg::REGBITS-1:0]   RdW
);
  import fpuPkg::*;

  fpOpT       opD;
  logic       isOpFp;
  logic       fRegWriteD, fWriteIntD;
  logic [6:0] funct7D;
  logic [2:0] rmD;
  logic [4:0] rs2D;

  assign funct7D = InstrD[31:25];  // fmt sits in [26:25]
  assign rmD     = InstrD[14:12];
  assign rs2D    = InstrD[24:20];
  assign isOpFp  = (InstrD[6:0] == OPFP);

  ////////////////////
  // Decode
  ////////////////////
  always_comb begin
    opD = opNone;
    if (isOpFp) begin
      case (funct7D)
        FSGNJ: begin
          case (rmD)
            3'd0: opD = opSgnj;
            3'd1: opD = opSgnjn;
            3'd2: opD = opSgnjx;
            default: opD = opNone;
          endcase
        end
        FMINMAX: begin
          if (rmD == 3'd0) opD = opMin;
          else if (rmD == 3'd1) opD = opMax;
        end
        FCMP: begin
          case (rmD)
            3'd2: opD = opFeq;
            3'd1: opD = opFlt;
            3'd0: opD = opFle;
            default: opD = opNone;
          endcase
        end
        FCLASSMV: if (rs2D == 5'd0 && rmD == 3'd1) opD = opClass;
                  else if (rs2D == 5'd0 && rmD == 3'd0) opD = opMvXW;
        FMVWX:    if (rs2D == 5'd0 && rmD == 3'd0) opD = opMvWX;
        default:  opD = opNone;  // Unknown funct7 or fmt
      endcase
    end
  end

  assign IllegalFPUInstrD = isOpFp & (opD == opNone);  // OP-FP that matched nothing
  assign fRegWriteD = opD inside {opSgnj, opSgnjn, opSgnjx, opMin, opMax, opMvWX};
  assign fWriteIntD = opD inside {opFeq, opFlt, opFle, opClass, opMvXW};

  ////////////////////
  // Control pipe
  ////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      ctrl.OpE        <= opNone;
      ctrl.Adr1E      <= '0;
      ctrl.Adr2E      <= '0;
      ctrl.RdE        <= '0;
      ctrl.FRegWriteE <= 1'b0;
      ctrl.FWriteIntE <= 1'b0;
      FRegWriteM      <= 1'b0;
      FWriteIntM      <= 1'b0;
      RdM             <= '0;
      FRegWriteW      <= 1'b0;
      RdW             <= '0;
    end else if (!Stall) begin            // Stall holds everything including the flush
      ctrl.Adr1E      <= InstrD[19:15];
      ctrl.Adr2E      <= InstrD[24:20];
      ctrl.RdE        <= InstrD[11:7];
      ctrl.OpE        <= FlushE ? opNone : opD;
      ctrl.FRegWriteE <= fRegWriteD & ~FlushE;
      ctrl.FWriteIntE <= fWriteIntD & ~FlushE;
      FRegWriteM      <= ctrl.FRegWriteE;  // E -> M
      FWriteIntM      <= ctrl.FWriteIntE;
      RdM             <= ctrl.RdE;
      FRegWriteW      <= FRegWriteM;       // M -> W
      RdW             <= RdM;
    end
  end

  // An instruction leaving M with an integer write must not show an FP write in W
  assert property (@(posedge clk) disable iff (!rstN)
    (FWriteIntM && !Stall) |=> !FRegWriteW)
    else $error("FP and integer write for one instruction");

endmodule

//--- hw/fexec.sv
// Execute datapath with forwarding, units, result select, E/M and M/W data registers
`timescale 1ns/100ps

module fexec (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     Stall,
  fpuCtrlIf.exec                   ctrl,
  input  logic [fpuPkg::FLEN-1:0]  Rd1,          // X source from the register file
  input  logic [fpuPkg::FLEN-1:0]  Rd2,          // Y source from the register file
  input  fpuPkg::fwdSelT           ForwardXE,
  input  fpuPkg::fwdSelT           ForwardYE,
  input  logic [fpuPkg::FLEN-1:0]  SrcAE,        // Integer source for fmv.w.x
  output logic [fpuPkg::FLEN-1:0]  FIntResM,
  output logic [4:0]               SetFflagsM,
  output logic [fpuPkg::FLEN-1:0]  FResultM,
  output logic [fpuPkg::FLEN-1:0]  FResultW
);
  import fpuPkg::*;

  logic [FLEN-1:0] xE, yE;
  logic            xs, ys, xZero, yZero, xSubnorm, xInf, xNaN, yNaN, xSNaN, ySNaN;
  logic [NE-1:0]   xe, ye;
  logic [NF:0]     xm, ym;
  logic [FLEN-1:0] cmpFpRes, cmpIntRes, sgnRes, classRes;
  logic            cmpNV;
  logic [FLEN-1:0] fpResE, intResE;
  logic [4:0]      flagsE;

  // Forwarding muxes
  assign xE = (ForwardXE == fwdM) ? FResultM : (ForwardXE == fwdW) ? FResultW : Rd1;
  assign yE = (ForwardYE == fwdM) ? FResultM : (ForwardYE == fwdW) ? FResultW : Rd2;

  unpack unpackX (.X(xE), .Xs(xs), .Xe(xe), .Xm(xm), .XZero(xZero), .XSubnorm(xSubnorm),
    .XInf(xInf), .XNaN(xNaN), .XSNaN(xSNaN));
  unpack unpackY (.X(yE), .Xs(ys), .Xe(ye), .Xm(ym), .XZero(yZero), .XSubnorm(),
    .XInf(), .XNaN(yNaN), .XSNaN(ySNaN));  // Y needs no class flags

  fcmp fcmpU (.Op(ctrl.OpE), .X(xE), .Y(yE), .Xs(xs), .Ys(ys), .Xe(xe), .Ye(ye), .Xm(xm),
    .Ym(ym), .XZero(xZero), .YZero(yZero), .XNaN(xNaN), .YNaN(yNaN), .XSNaN(xSNaN),
    .YSNaN(ySNaN), .CmpFpRes(cmpFpRes), .CmpIntRes(cmpIntRes), .CmpNV(cmpNV));

  fsgnClass fsgnClassU (.Op(ctrl.OpE), .X(xE), .Xs(xs), .Ys(ys), .XZero(xZero),
    .XSubnorm(xSubnorm), .XInf(xInf), .XNaN(xNaN), .XSNaN(xSNaN),
    .SgnRes(sgnRes), .ClassRes(classRes));

  ////////////////////
  // Result select
  ////////////////////
  always_comb begin
    fpResE  = '0;
    intResE = '0;
    case (ctrl.OpE)
      opSgnj, opSgnjn, opSgnjx: fpResE  = sgnRes;
      opMin, opMax:             fpResE  = cmpFpRes;
      opMvWX:                   fpResE  = SrcAE;     // Bit pattern moved as is
      opFeq, opFlt, opFle:      intResE = cmpIntRes;
      opClass:                  intResE = classRes;
      opMvXW:                   intResE = xE;        // Raw bits to integer side
      default:                  fpResE  = '0;
    endcase
  end

  always_comb begin
    flagsE = '0;
    flagsE[NV_BIT] = cmpNV;  // fcmp already qualifies by op
  end

  // NV of the instruction entering M
  always_ff @(posedge clk) begin
    if (!rstN)       SetFflagsM <= '0;
    else if (!Stall) SetFflagsM <= flagsE;
  end

  always_ff @(posedge clk) begin
    if (!Stall) begin
      FIntResM <= intResE;
      FResultM <= fpResE;
      FResultW <= FResultM;   // M -> W
    end
  end

  // Only NV can ever reach the flag output
  assert property (@(posedge clk) disable iff (!rstN)
    (SetFflagsM & ~(5'b1 << NV_BIT)) == 5'b0)
    else $error("Unexpected fflags bit %b", SetFflagsM);

endmodule

//--- hw/fsgnClass.sv
// Sign injection results and the fclass mask
`timescale 1ns/100ps

module fsgnClass (
  input  fpuPkg::fpOpT             Op,
  input  logic [fpuPkg::FLEN-1:0]  X,
  input  logic                     Xs,
  input  logic                     Ys,
  input  logic                     XZero,
  input  logic                     XSubnorm,
  input  logic                     XInf,
  input  logic                     XNaN,
  input  logic                     XSNaN,
  output logic [fpuPkg::FLEN-1:0]  SgnRes,
  output logic [fpuPkg::FLEN-1:0]  ClassRes
);
  import fpuPkg::*;

  logic newSign;
  logic xNorm;

  ////////////////////
  // Sign injection
  ////////////////////
  always_comb begin
    case (Op)
      opSgnj:  newSign = Ys;
      opSgnjn: newSign = ~Ys;
      opSgnjx: newSign = Xs ^ Ys;
      default: newSign = Xs;      // Leaves X untouched
    endcase
  end
  assign SgnRes = {newSign, X[FLEN-2:0]};  // Magnitude of X kept

  ////////////////////
  // Classify
  ////////////////////
  assign xNorm = ~(XZero | XSubnorm | XInf | XNaN);

  always_comb begin
    ClassRes = '0;                          // Upper bits stay zero
    ClassRes[CLS_NEGINF]  = Xs & XInf;
    ClassRes[CLS_NEGNORM] = Xs & xNorm;
    ClassRes[CLS_NEGSUB]  = Xs & XSubnorm;
    ClassRes[CLS_NEGZERO] = Xs & XZero;
    ClassRes[CLS_POSZERO] = ~Xs & XZero;
    ClassRes[CLS_POSSUB]  = ~Xs & XSubnorm;
    ClassRes[CLS_POSNORM] = ~Xs & xNorm;
    ClassRes[CLS_POSINF]  = ~Xs & XInf;
    ClassRes[CLS_SNAN]    = XSNaN;          // Sign ignored for NaNs
    ClassRes[CLS_QNAN]    = XNaN & ~XSNaN;
  end

endmodule

//--- hw/fcmp.sv
// Compare (feq, flt, fle), min/max and the compare invalid flag
`timescale 1ns/100ps

module fcmp (
  input  fpuPkg::fpOpT             Op,
  input  logic [fpuPkg::FLEN-1:0]  X,
  input  logic [fpuPkg::FLEN-1:0]  Y,
  input  logic                     Xs, Ys,
  input  logic [fpuPkg::NE-1:0]    Xe, Ye,
  input  logic [fpuPkg::NF:0]      Xm, Ym,
  input  logic                     XZero, YZero,
  input  logic                     XNaN, YNaN,
  input  logic                     XSNaN, YSNaN,
  output logic [fpuPkg::FLEN-1:0]  CmpFpRes,   // fmin / fmax
  output logic [fpuPkg::FLEN-1:0]  CmpIntRes,  // feq / flt / fle
  output logic                     CmpNV
);
  import fpuPkg::*;

  logic magLt, magEq;
  logic anyNaN, bothZero;
  logic eq, lt;
  logic ltSigned;  // Ordering with -0 below +0

  // Exponent then significand orders magnitudes
  assign magLt = {Xe, Xm} < {Ye, Ym};
  assign magEq = {Xe, Xm} == {Ye, Ym};

  assign anyNaN   = XNaN | YNaN;
  assign bothZero = XZero & YZero;

  assign ltSigned = (Xs != Ys) ? Xs :
                    Xs ? (~magLt & ~magEq) : magLt;  // Negatives order reversed

  assign eq = ~anyNaN & (bothZero | (magEq & (Xs == Ys)));
  assign lt = ~anyNaN & ~bothZero & ltSigned;        // +0 and -0 compare equal

  ////////////////////
  // Results
  ////////////////////
  always_comb begin
    CmpIntRes = '0;
    case (Op)
      opFeq:   CmpIntRes[0] = eq;
      opFlt:   CmpIntRes[0] = lt;
      opFle:   CmpIntRes[0] = lt | eq;
      default: CmpIntRes    = '0;
    endcase
  end

  always_comb begin
    if (XNaN & YNaN)  CmpFpRes = CANONNAN;
    else if (XNaN)    CmpFpRes = Y;                   // NaN loses to a number
    else if (YNaN)    CmpFpRes = X;
    else if (Op == opMax) CmpFpRes = ltSigned ? Y : X;
    else              CmpFpRes = ltSigned ? X : Y;    // fmin
  end

  always_comb begin
    case (Op)
      opFeq, opMin, opMax: CmpNV = XSNaN | YSNaN;     // Quiet compares
      opFlt, opFle:        CmpNV = anyNaN;            // Signaling compares
      default:             CmpNV = 1'b0;
    endcase
  end

endmodule

//--- hw/unpack.sv
// Operand unpacker: sign, exponent, significand and special-value flags
`timescale 1ns/100ps

module unpack (
  input  logic [fpuPkg::FLEN-1:0] X,
  output logic                    Xs,
  output logic [fpuPkg::NE-1:0]   Xe,
  output logic [fpuPkg::NF:0]     Xm,        // Hidden bit included
  output logic                    XZero,
  output logic                    XSubnorm,
  output logic                    XInf,
  output logic                    XNaN,
  output logic                    XSNaN
);
  import fpuPkg::*;

  logic expZero, expMax, fracZero;

  assign Xs       = X[FLEN-1];
  assign Xe       = X[FLEN-2:NF];
  assign expZero  = ~|Xe;
  assign expMax   = &Xe;
  assign fracZero = ~|X[NF-1:0];
  assign Xm       = {~expZero, X[NF-1:0]};  // Implicit one unless subnormal or zero

  assign XZero    = expZero & fracZero;
  assign XSubnorm = expZero & ~fracZero;
  assign XInf     = expMax & fracZero;
  assign XNaN     = expMax & ~fracZero;
  assign XSNaN    = XNaN & ~X[NF-1];         // Quiet bit is the fraction MSB

endmodule

//--- hw/fpuCtrlIf.sv
// Execute-stage control bundle between the decoder and the datapath
`timescale 1ns/100ps

interface fpuCtrlIf (
  input logic clk,
  input logic rstN
);
  import fpuPkg::*;

  fpOpT               OpE;         // Operation in E
  logic [REGBITS-1:0] Adr1E;       // Source 1 (X)
  logic [REGBITS-1:0] Adr2E;       // Source 2 (Y)
  logic [REGBITS-1:0] RdE;         // Destination
  logic               FRegWriteE;  // Writes FP register
  logic               FWriteIntE;  // Writes integer register

  // Decoder owns the E-stage registers
  modport dec (
    output OpE, Adr1E, Adr2E, RdE, FRegWriteE, FWriteIntE
  );

  // Datapath and hazard side, clock for checks
  modport exec (
    input clk, rstN, OpE, Adr1E, Adr2E, RdE, FRegWriteE, FWriteIntE
  );

endinterface

//--- hw/fpuPkg.sv
// Widths, opcode and funct7 constants, operation and forwarding enums, fclass bit positions
package fpuPkg;

  ////////////////////
  // Widths
  ////////////////////
  localparam int FLEN    = 32;  // Single precision only
  localparam int NE      = 8;   // Exponent bits
  localparam int NF      = 23;  // Fraction bits
  localparam int REGBITS = 5;   // FP register address

  ////////////////////
  // Encodings
  ////////////////////
  localparam logic [6:0] OPFP     = 7'b1010011;  // OP-FP major opcode
  // funct7 with fmt 00 in the low two bits
  localparam logic [6:0] FSGNJ    = 7'b0010000;
  localparam logic [6:0] FMINMAX  = 7'b0010100;
  localparam logic [6:0] FCMP     = 7'b1010000;
  localparam logic [6:0] FCLASSMV = 7'b1110000;  // fclass and fmv.x.w share it
  localparam logic [6:0] FMVWX    = 7'b1111000;

  localparam logic [FLEN-1:0] CANONNAN = 32'h7fc00000;  // Quiet NaN, positive, zero payload

  // Operation carried down the pipe
  typedef enum logic [3:0] {
    opNone, opSgnj, opSgnjn, opSgnjx, opMin, opMax,
    opFeq, opFlt, opFle, opClass, opMvXW, opMvWX
  } fpOpT;

  // Operand source in E
  typedef enum logic [1:0] {
    fwdReg = 2'b00,  // Register file
    fwdW   = 2'b01,  // Writeback result
    fwdM   = 2'b10   // Memory-stage result
  } fwdSelT;

  // fclass mask bits
  localparam int CLS_NEGINF  = 0;
  localparam int CLS_NEGNORM = 1;
  localparam int CLS_NEGSUB  = 2;
  localparam int CLS_NEGZERO = 3;
  localparam int CLS_POSZERO = 4;
  localparam int CLS_POSSUB  = 5;
  localparam int CLS_POSNORM = 6;
  localparam int CLS_POSINF  = 7;
  localparam int CLS_SNAN    = 8;
  localparam int CLS_QNAN    = 9;

  localparam int NV_BIT = 4;  // Invalid flag in fflags

endpackage
